//--- hdl/timer_pkg.sv
package timer_pkg;

    // clock phases that make up one time pulse
    // each phase lasts exactly one clock
    localparam int PHASES = 4;

    // width of the phase counter in the sequencer
    localparam int PHASE_W = 2;

    // phase index of each strobe
    // the strobes follow each other in this order and repeat every PHASES clocks
    // read pulse, first strobe of the slot
    localparam logic [PHASE_W-1:0] PH_RT = 2'd0;

    // second phase, no further use in this block
    localparam logic [PHASE_W-1:0] PH_PHS2 = 2'd1;

    // write pulse
    localparam logic [PHASE_W-1:0] PH_WT = 2'd2;

    // clear pulse
    // odd set and even set are decoded in this phase as well
    localparam logic [PHASE_W-1:0] PH_CT = 2'd3;

    // time pulses T01 to T12 in one memory cycle
    // also the width of the one-hot time pulse bus
    localparam int TIME_PULSES = 12;

    // bit of T12 in the one-hot bus
    // T01 sits in bit 0, so the odd pulses sit in the even bits
    // gojam and reset both park the ring here
    localparam int T12_IDX = 11;

endpackage

//--- hdl/phase_sequencer.sv
module phase_sequencer (
    input  logic clock,
    input  logic rst,
    input  logic stop,
    output logic rt,
    output logic phs2,
    output logic wt,
    output logic ct,
    output logic ring_a,
    output logic oddset,
    output logic evnset
);

    import timer_pkg::*;

    // phase that the strobe registers show on the following clock
    logic [PHASE_W-1:0] phase;
    logic               last_phase;

    // the counter wraps after the final phase of the slot
    assign last_phase = (phase == PHASE_W'(PHASES - 1));

    // free running divider, one count per clock
    // stop does not hold it, the machine keeps ticking in ring B
    always_ff @(posedge clock) begin
        if (rst) begin
            phase <= '0;
        end else if (last_phase) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // phase strobes
    // registered decode of the counter, so every strobe lags the count by one clock
    // right after reset all of them are low for one clock, then rt opens the slot
    always_ff @(posedge clock) begin
        if (rst) begin
            rt   <= 1'b0;
            phs2 <= 1'b0;
            wt   <= 1'b0;
            ct   <= 1'b0;
        end else begin
            rt   <= (phase == PH_RT);
            phs2 <= (phase == PH_PHS2);
            wt   <= (phase == PH_WT);
            ct   <= (phase == PH_CT);
        end
    end

    // ring A / ring B slot flag
    // flips on the edge that closes the ct clock
    // so it stays level across the four strobes of one slot
    always_ff @(posedge clock) begin
        if (rst) begin
            ring_a <= 1'b1;
        end else if (ct) begin
            ring_a <= !ring_a;
        end
    end

    // set strobes, high together with ct
    // ring A slots give odd sets, ring B slots give even sets
    // stop masks only the odd set
    // the time pulse ring then cannot leave an even pulse and parks in T12
    always_ff @(posedge clock) begin
        if (rst) begin
            oddset <= 1'b0;
            evnset <= 1'b0;
        end else begin
            oddset <= (phase == PH_CT) && ring_a && !stop;
            evnset <= (phase == PH_CT) && !ring_a;
        end
    end

endmodule

//--- hdl/time_pulse_gen.sv
module time_pulse_gen (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             oddset,
    input  logic                             evnset,
    input  logic                             gojam,
    output logic [timer_pkg::TIME_PULSES-1:0] time_pulse
);

    import timer_pkg::*;

    // one-hot value with only T12 set
    logic [TIME_PULSES-1:0] t12_only;
    // candidate for the next pulse, T12 wraps round to T01
    logic [TIME_PULSES-1:0] rotated;
    // next pulse has an odd number
    logic                   next_is_odd;
    // set strobe that belongs to the next pulse is present
    logic                   advance;

    assign t12_only = TIME_PULSES'(1) << T12_IDX;

    // rotate left by one
    // bit i holds pulse T(i+1)
    assign rotated = {time_pulse[TIME_PULSES-2:0], time_pulse[T12_IDX]};

    // odd pulses T01, T03 .. T11 live in the even bit positions
    always_comb begin
        next_is_odd = 1'b0;
        for (int i = 0; i < TIME_PULSES; i += 2) begin
            next_is_odd = next_is_odd | rotated[i];
        end
    end

    // an odd pulse is entered only on oddset
    // an even pulse only on evnset
    // with oddset masked by stop, T12 cannot advance to T01
    assign advance = next_is_odd ? oddset : evnset;

    // memory cycle position
    // new pulse shows one clock after the set strobe and holds 4 clocks
    always_ff @(posedge clock) begin
        if (rst) begin
            time_pulse <= t12_only;
        end else if (gojam) begin
            // jam wins over any pending advance
            time_pulse <= t12_only;
        end else if (advance) begin
            time_pulse <= rotated;
        end
    end

endmodule

//--- hdl/restart_ctrl.sv
module restart_ctrl (
    input  logic clock,
    input  logic rst,
    input  logic sby,
    input  logic alga,
    input  logic mstrtp,
    input  logic strt1,
    input  logic strt2,
    input  logic mstp,
    input  logic evnset,
    input  logic t12,
    output logic stop,
    output logic gojam
);

    // any restart request, plain level OR
    logic goset;
    // restart stop latch, held until the cycle ends cleanly in T12
    logic stopa;
    // monitor stop latch
    logic mstp_q;
    // end of memory cycle, even set inside T12
    logic cycle_end;

    // standby, alarm, manual restart and both start inputs
    assign goset = sby | alga | mstrtp | strt1 | strt2;

    assign cycle_end = evnset & t12;

    // stopa
    // set one clock after any restart request
    // released only at a cycle end with no request pending
    // comes up set after reset, which gives the power-on restart
    always_ff @(posedge clock) begin
        if (rst) begin
            stopa <= 1'b1;
        end else if (goset) begin
            stopa <= 1'b1;
        end else if (cycle_end) begin
            stopa <= 1'b0;
        end
    end

    // monitor stop samples mstp only at a cycle end
    // a stop request thus lets the running cycle finish
    // and the release waits for the next T12 even set
    always_ff @(posedge clock) begin
        if (rst) begin
            mstp_q <= 1'b0;
        end else if (cycle_end) begin
            mstp_q <= mstp;
        end
    end

    // stop masks the odd set in the sequencer
    assign stop = stopa | mstp_q;

    // strt2 jams at once, without waiting for the latch
    // the other sources reach gojam through stopa one clock later
    assign gojam = stopa | strt2;

endmodule

//--- hdl/overflow_detect.sv
module overflow_detect (
    input  logic clock,
    input  logic rst,
    input  logic ct,
    input  logic wl15,
    input  logic wl16,
    output logic ovf,
    output logic unf
);

    // ct divided by two
    logic ovf_tog;
    // overflow strobe, every second ct
    logic ovfstb;

    assign ovfstb = ct & ovf_tog;

    // flips on every ct
    always_ff @(posedge clock) begin
        if (rst) begin
            ovf_tog <= 1'b0;
        end else if (ct) begin
            ovf_tog <= !ovf_tog;
        end
    end

    // top two bits of the write bus disagree on overflow or underflow
    // 01 in wl16/wl15 is a positive overflow, 10 a negative one
    // result holds until the next strobe
    always_ff @(posedge clock) begin
        if (rst) begin
            ovf <= 1'b0;
            unf <= 1'b0;
        end else if (ovfstb) begin
            ovf <= wl15 & !wl16;
            unf <= wl16 & !wl15;
        end
    end

endmodule

//--- hdl/a2_timer.sv
module a2_timer (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             sby,
    input  logic                             alga,
    input  logic                             mstrtp,
    input  logic                             strt1,
    input  logic                             strt2,
    input  logic                             mstp,
    input  logic                             wl15,
    input  logic                             wl16,
    output logic                             rt,
    output logic                             phs2,
    output logic                             wt,
    output logic                             ct,
    output logic                             ring_a,
    output logic                             oddset,
    output logic                             evnset,
    output logic [timer_pkg::TIME_PULSES-1:0] time_pulse,
    output logic                             stop,
    output logic                             gojam,
    output logic                             ovf,
    output logic                             unf
);

    import timer_pkg::*;

    // phase strobes and slot timing
    phase_sequencer u_phase_sequencer (
        .clock  (clock),
        .rst    (rst),
        .stop   (stop),
        .rt     (rt),
        .phs2   (phs2),
        .wt     (wt),
        .ct     (ct),
        .ring_a (ring_a),
        .oddset (oddset),
        .evnset (evnset)
    );

    // T01 to T12 ring
    time_pulse_gen u_time_pulse_gen (
        .clock      (clock),
        .rst        (rst),
        .oddset     (oddset),
        .evnset     (evnset),
        .gojam      (gojam),
        .time_pulse (time_pulse)
    );

    // restart and stop, released at the end of T12
    restart_ctrl u_restart_ctrl (
        .clock  (clock),
        .rst    (rst),
        .sby    (sby),
        .alga   (alga),
        .mstrtp (mstrtp),
        .strt1  (strt1),
        .strt2  (strt2),
        .mstp   (mstp),
        .evnset (evnset),
        .t12    (time_pulse[T12_IDX]),
        .stop   (stop),
        .gojam  (gojam)
    );

    // write bus sign check
    overflow_detect u_overflow_detect (
        .clock (clock),
        .rst   (rst),
        .ct    (ct),
        .wl15  (wl15),
        .wl16  (wl16),
        .ovf   (ovf),
        .unf   (unf)
    );

endmodule

//--- test/timer_tb.sv
module timer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import timer_pkg::*;

    // one row of stimulus
    // slots counts time pulses and each one ends with a ct strobe
    typedef struct packed {
        logic       sby;
        logic       alga;
        logic       mstrtp;
        logic       strt1;
        logic       strt2;
        logic       mstp;
        logic       rand_wl;
        logic [7:0] slots;
        logic       exp_stop;
    } step_t;

    localparam int NUM_STEPS = 23;

    logic                   clock;
    logic                   rst;
    logic                   sby;
    logic                   alga;
    logic                   mstrtp;
    logic                   strt1;
    logic                   strt2;
    logic                   mstp;
    logic                   wl15;
    logic                   wl16;
    logic                   rt;
    logic                   phs2;
    logic                   wt;
    logic                   ct;
    logic                   ring_a;
    logic                   oddset;
    logic                   evnset;
    logic [TIME_PULSES-1:0] time_pulse;
    logic                   stop;
    logic                   gojam;
    logic                   ovf;
    logic                   unf;

    step_t steps [NUM_STEPS];

    // reference model state
    int   m_phase;
    // phase shown by the strobes
    // -1 in the first clock after reset
    int   m_strobe;
    logic m_ring_a;
    logic m_oddset;
    logic m_evnset;
    logic m_stopa;
    logic m_mstp_q;
    logic m_tog;
    logic m_ovf;
    logic m_unf;
    // current time pulse number from 1 to 12
    int   m_tp;

    logic [31:0] rand_state;

    // samples of the previous clock for the pulse entry check
    logic [TIME_PULSES-1:0] prev_tp;
    logic                   prev_oddset;
    logic                   prev_evnset;
    logic                   prev_gojam;
    logic                   prev_valid = 1'b0;

    // sign-bit outcomes reached by the overflow rows
    logic seen_ovf = 1'b0;
    logic seen_unf = 1'b0;

    a2_timer UUT (
        .clock      (clock),
        .rst        (rst),
        .sby        (sby),
        .alga       (alga),
        .mstrtp     (mstrtp),
        .strt1      (strt1),
        .strt2      (strt2),
        .mstp       (mstp),
        .wl15       (wl15),
        .wl16       (wl16),
        .rt         (rt),
        .phs2       (phs2),
        .wt         (wt),
        .ct         (ct),
        .ring_a     (ring_a),
        .oddset     (oddset),
        .evnset     (evnset),
        .time_pulse (time_pulse),
        .stop       (stop),
        .gojam      (gojam),
        .ovf        (ovf),
        .unf        (unf)
    );

    always #10 clock = !clock;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else
            abort_run($sformatf("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual));
    endtask

    task automatic check_vec(input string name, input logic [TIME_PULSES-1:0] expected,
                             input logic [TIME_PULSES-1:0] actual);
        assert (actual === expected) else
            abort_run($sformatf("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual));
    endtask

    // xorshift32 generator for the write bus bits of the overflow rows
    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // T01 is bit 0, so odd pulses sit at even positions
    function automatic logic is_odd_pulse(input logic [TIME_PULSES-1:0] tp);
        logic odd;
        odd = 1'b0;
        for (int i = 0; i < TIME_PULSES; i += 2) begin
            odd = odd | tp[i];
        end
        return odd;
    endfunction

    // advance the model by one clock edge with the inputs sampled on that edge
    task automatic model_step();
        logic goset;
        logic stop_q;
        logic gojam_q;
        logic cycle_end;
        logic ct_q;
        int   next_tp;
        if (rst) begin
            m_phase  = 0;
            m_strobe = -1;
            m_ring_a = 1'b1;
            m_oddset = 1'b0;
            m_evnset = 1'b0;
            m_stopa  = 1'b1;
            m_mstp_q = 1'b0;
            m_tog    = 1'b0;
            m_ovf    = 1'b0;
            m_unf    = 1'b0;
            m_tp     = TIME_PULSES;
        end else begin
            goset     = sby | alga | mstrtp | strt1 | strt2;
            stop_q    = m_stopa | m_mstp_q;
            gojam_q   = m_stopa | strt2;
            cycle_end = m_evnset && (m_tp == TIME_PULSES);
            ct_q      = (m_strobe == int'(PH_CT));
            // gojam parks at T12 and otherwise the ring steps on the set of matching parity
            next_tp = (m_tp % TIME_PULSES) + 1;
            if (gojam_q) begin
                m_tp = TIME_PULSES;
            end else if ((next_tp % 2 == 1) ? m_oddset : m_evnset) begin
                m_tp = next_tp;
            end
            // overflow strobe on every second ct
            if (ct_q && m_tog) begin
                m_ovf = wl15 && !wl16;
                m_unf = wl16 && !wl15;
            end
            if (ct_q) begin
                m_tog = !m_tog;
            end
            // sets come out with ct and use the ring of the current slot
            m_oddset = (m_phase == PHASES - 1) && m_ring_a && !stop_q;
            m_evnset = (m_phase == PHASES - 1) && !m_ring_a;
            if (ct_q) begin
                m_ring_a = !m_ring_a;
            end
            m_strobe = m_phase;
            m_phase  = (m_phase + 1) % PHASES;
            if (goset) begin
                m_stopa = 1'b1;
            end else if (cycle_end) begin
                m_stopa = 1'b0;
            end
            if (cycle_end) begin
                m_mstp_q = mstp;
            end
        end
    endtask

    // compare every output with the model and check properties that need no model
    task automatic check_outputs();
        logic [TIME_PULSES-1:0] exp_tp;
        exp_tp = TIME_PULSES'(1) << (m_tp - 1);
        check_bit("rt", m_strobe == int'(PH_RT), rt);
        check_bit("phs2", m_strobe == int'(PH_PHS2), phs2);
        check_bit("wt", m_strobe == int'(PH_WT), wt);
        check_bit("ct", m_strobe == int'(PH_CT), ct);
        check_bit("ring_a", m_ring_a, ring_a);
        check_bit("oddset", m_oddset, oddset);
        check_bit("evnset", m_evnset, evnset);
        check_vec("time_pulse", exp_tp, time_pulse);
        check_bit("stop", m_stopa | m_mstp_q, stop);
        // strt2 reaches gojam within the same clock
        check_bit("gojam", m_stopa | strt2, gojam);
        check_bit("ovf", m_ovf, ovf);
        check_bit("unf", m_unf, unf);
        seen_ovf = seen_ovf | m_ovf;
        seen_unf = seen_unf | m_unf;
        if (m_strobe >= 0) begin
            assert ($onehot({rt, phs2, wt, ct})) else
                abort_run("phase strobes are not one-hot");
        end
        assert ($onehot(time_pulse)) else
            abort_run("time_pulse is not one-hot");
        assert (ct || !(oddset || evnset)) else
            abort_run("set strobe seen outside ct");
        assert (!(oddset && !ring_a) && !(evnset && ring_a)) else
            abort_run("set strobe in the wrong ring slot");
        assert (!(ovf && unf)) else
            abort_run("ovf and unf high together");
        // a new pulse must follow the set strobe of its own parity
        if (prev_valid && !prev_gojam && time_pulse != prev_tp) begin
            if (is_odd_pulse(time_pulse)) begin
                assert (prev_oddset) else
                    abort_run("odd time pulse entered without oddset");
            end else begin
                assert (prev_evnset) else
                    abort_run("even time pulse entered without evnset");
            end
        end
        prev_tp     = time_pulse;
        prev_oddset = oddset;
        prev_evnset = evnset;
        prev_gojam  = gojam;
        prev_valid  = 1'b1;
    endtask

    // each row holds sby alga mstrtp strt1 strt2 mstp rand_wl, slots and the stop at the last ct
    task automatic load_steps();
        // power-on restart and then one full cycle
        steps[0]  = {7'b0000000, 8'd4, 1'b0};
        steps[1]  = {7'b0000000, 8'd12, 1'b0};
        // start jam and its release in the next T12 even slot
        steps[2]  = {7'b0000100, 8'd2, 1'b1};
        steps[3]  = {7'b0000000, 8'd4, 1'b0};
        steps[4]  = {7'b1000000, 8'd1, 1'b1};
        steps[5]  = {7'b0000000, 8'd3, 1'b0};
        steps[6]  = {7'b0100000, 8'd2, 1'b1};
        steps[7]  = {7'b0000000, 8'd3, 1'b0};
        steps[8]  = {7'b0010000, 8'd1, 1'b1};
        // still stopped as the release comes one slot later
        steps[9]  = {7'b0000000, 8'd2, 1'b1};
        steps[10] = {7'b0001000, 8'd1, 1'b1};
        steps[11] = {7'b0000000, 8'd4, 1'b0};
        // a running ring never shows evnset in T12, so mstp is not sampled
        steps[12] = {7'b0000010, 8'd12, 1'b0};
        // parked at T12 the latch takes mstp and holds stop
        steps[13] = {7'b0000110, 8'd1, 1'b1};
        steps[14] = {7'b0000010, 8'd4, 1'b1};
        steps[15] = {7'b0000000, 8'd4, 1'b0};
        // write bus sign bits
        steps[16] = {7'b0000001, 8'd2, 1'b0};
        steps[17] = {7'b0000001, 8'd2, 1'b0};
        steps[18] = {7'b0000001, 8'd2, 1'b0};
        steps[19] = {7'b0000001, 8'd2, 1'b0};
        steps[20] = {7'b0000001, 8'd2, 1'b0};
        steps[21] = {7'b0000001, 8'd2, 1'b0};
        steps[22] = {7'b0000000, 8'd12, 1'b0};
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] r;
        sby    = s.sby;
        alga   = s.alga;
        mstrtp = s.mstrtp;
        strt1  = s.strt1;
        strt2  = s.strt2;
        mstp   = s.mstp;
        if (s.rand_wl) begin
            // bits 2 and 3 of the random word feed wl15 and wl16
            r    = next_rand();
            wl15 = r[2];
            wl16 = r[3];
        end else begin
            wl15 = 1'b0;
            wl16 = 1'b0;
        end
    endtask

    // returns at the falling edge inside the next ct clock
    task automatic wait_ct();
        int   count;
        logic seen;
        count = 0;
        seen  = 1'b0;
        while (!seen && count < 2 * PHASES) begin
            @(negedge clock);
            seen  = ct;
            count = count + 1;
        end
        assert (seen) else
            abort_run("timeout while waiting for the ct strobe");
    endtask

    always @(posedge clock) begin
        model_step();
    end

    // outputs are settled by the falling edge
    always @(negedge clock) begin
        if (!rst) begin
            check_outputs();
        end
    end

    initial begin
        clock      = 1'b0;
        rst        = 1'b1;
        sby        = 1'b0;
        alga       = 1'b0;
        mstrtp     = 1'b0;
        strt1      = 1'b0;
        strt2      = 1'b0;
        mstp       = 1'b0;
        wl15       = 1'b0;
        wl16       = 1'b0;
        rand_state = 32'd99221;
        load_steps();
        repeat (2) @(posedge clock);
        #2;
        rst = 1'b0;
        for (int i = 0; i < NUM_STEPS; i++) begin
            apply_step(steps[i]);
            repeat (steps[i].slots) wait_ct();
            check_bit($sformatf("stop after step %0d", i), steps[i].exp_stop, stop);
            @(posedge clock);
            #2;
        end
        assert (seen_ovf && seen_unf) else
            abort_run("overflow rows never produced both an ovf and an unf case");
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- tb.f
hdl/timer_pkg.sv
hdl/phase_sequencer.sv
hdl/time_pulse_gen.sv
hdl/restart_ctrl.sv
hdl/overflow_detect.sv
hdl/a2_timer.sv
test/timer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the timer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module timer_tb -o timer_tb
./obj_dir/timer_tb
